// ==== Makefile ====
SOURCES := $(shell cat core6809.f)

all: run

obj_dir/Vcore6809_tb: core6809.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module core6809_tb -f core6809.f -o Vcore6809_tb

run: obj_dir/Vcore6809_tb
	./obj_dir/Vcore6809_tb | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== core6809.f ====
design/cpu_isa_pkg.sv
design/core_ctrl_pkg.sv
design/fetch_sequencer.sv
design/opcode_decode.sv
design/arith_unit.sv
design/shift_unit.sv
design/accumulator_update.sv
design/core6809.sv
testbench/tb_clock_gen.sv
testbench/core6809_tb.sv

// ==== design/accumulator_update.sv ====
`timescale 1ns/10ps
`default_nettype none

module accumulator_update (
  input  wire                             clk,
  input  wire                             reset_b,
  input  wire core_ctrl_pkg::alu_class_t  op_class,
  input  wire                             target_b,
  input  wire cpu_isa_pkg::byte_t         arith_result,
  input  wire                             arith_n,
  input  wire                             arith_z,
  input  wire                             arith_v,
  input  wire                             arith_c,
  input  wire cpu_isa_pkg::byte_t         shift_result,
  input  wire                             shift_n,
  input  wire                             shift_z,
  input  wire                             shift_v,
  input  wire                             shift_c,
  output cpu_isa_pkg::byte_t              reg_a,
  output cpu_isa_pkg::byte_t              reg_b,
  output cpu_isa_pkg::cc_t                cond_codes,
  output cpu_isa_pkg::byte_t              operand
);

  import cpu_isa_pkg::*;
  import core_ctrl_pkg::*;

  // --------------------------------------------------
  // Writeback selection
  // --------------------------------------------------

  byte_t wb_value;
  logic  wb_n;
  logic  wb_z;
  logic  wb_v;
  logic  wb_c;
  logic  wb_en;
  cc_t   cc_next;

  // Source accumulator for both units
  assign operand = target_b ? reg_b : reg_a;

  always_comb begin
    wb_en    = 1'b1;
    wb_value = arith_result;
    wb_n     = arith_n;
    wb_z     = arith_z;
    wb_v     = arith_v;
    wb_c     = arith_c;
    case (op_class)
      CLASS_ARITH: wb_en = 1'b1;
      CLASS_SHIFT: begin
        wb_value = shift_result;
        wb_n     = shift_n;
        wb_z     = shift_z;
        wb_v     = shift_v;
        wb_c     = shift_c;
      end
      default: wb_en = 1'b0;
    endcase
  end

  // H, E, F and I pass through untouched
  always_comb begin
    cc_next       = cond_codes;
    cc_next[CC_N] = wb_n;
    cc_next[CC_Z] = wb_z;
    cc_next[CC_V] = wb_v;
    cc_next[CC_C] = wb_c;
  end

  // --------------------------------------------------
  // Register file
  // --------------------------------------------------

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      reg_a      <= '0;
      reg_b      <= '0;
      cond_codes <= CC_RESET;
    end else if (wb_en) begin
      // Only the targeted accumulator changes
      if (target_b) begin
        reg_b <= wb_value;
      end else begin
        reg_a <= wb_value;
      end
      cond_codes <= cc_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/arith_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module arith_unit (
  input  wire core_ctrl_pkg::alu_op_t op,
  input  wire cpu_isa_pkg::byte_t     operand,
  input  wire                         carry_in,
  output cpu_isa_pkg::byte_t          result,
  output logic                        flag_n,
  output logic                        flag_z,
  output logic                        flag_v,
  output logic                        flag_c
);

  import cpu_isa_pkg::*;
  import core_ctrl_pkg::*;

  // --------------------------------------------------
  // Result
  // --------------------------------------------------

  byte_t inc_value;

  // Wraps FF to 00
  assign inc_value = operand + 8'd1;

  always_comb begin
    case (op)
      OP_CLR:  result = '0;
      OP_INC:  result = inc_value;
      OP_COM:  result = ~operand;
      default: result = operand;
    endcase
  end

  // --------------------------------------------------
  // Flags
  // --------------------------------------------------

  // N and Z straight from the result
  assign flag_n = result[7];
  assign flag_z = (result == 8'h00);

  always_comb begin
    case (op)
      OP_INC: begin
        // Signed overflow only going 7F to 80
        flag_v = (operand == 8'h7F);
        flag_c = carry_in;
      end
      OP_COM: begin
        flag_v = 1'b0;
        flag_c = 1'b1;
      end
      default: begin
        // CLR clears both V and C
        flag_v = 1'b0;
        flag_c = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/core6809.sv ====
`timescale 1ns/10ps
`default_nettype none

module core6809 (
  input  wire                     clk,
  input  wire                     reset_b,
  input  wire cpu_isa_pkg::byte_t data_in,
  output cpu_isa_pkg::addr_t      memory_addr,
  output logic                    memory_rw_n,
  output cpu_isa_pkg::byte_t      reg_a,
  output cpu_isa_pkg::byte_t      reg_b,
  output cpu_isa_pkg::cc_t        cond_codes
);

  import cpu_isa_pkg::*;
  import core_ctrl_pkg::*;

  // --------------------------------------------------
  // Internal wiring
  // --------------------------------------------------

  byte_t      instr;
  alu_op_t    op;
  alu_class_t op_class;
  logic       target_b;
  byte_t      operand;

  // Arithmetic unit outputs
  byte_t      arith_result;
  logic       arith_n;
  logic       arith_z;
  logic       arith_v;
  logic       arith_c;

  // Shift unit outputs
  byte_t      shift_result;
  logic       shift_n;
  logic       shift_z;
  logic       shift_v;
  logic       shift_c;

  // --------------------------------------------------
  // Fetch and decode
  // --------------------------------------------------

  fetch_sequencer fetch_sequencer_inst (
    .clk         (clk),
    .reset_b     (reset_b),
    .data_in     (data_in),
    .memory_addr (memory_addr),
    .memory_rw_n (memory_rw_n),
    .instr       (instr)
  );

  opcode_decode opcode_decode_inst (
    .instr    (instr),
    .op       (op),
    .op_class (op_class),
    .target_b (target_b)
  );

  // --------------------------------------------------
  // Execute
  // --------------------------------------------------

  // INC keeps the current carry
  arith_unit arith_unit_inst (
    .op       (op),
    .operand  (operand),
    .carry_in (cond_codes[CC_C]),
    .result   (arith_result),
    .flag_n   (arith_n),
    .flag_z   (arith_z),
    .flag_v   (arith_v),
    .flag_c   (arith_c)
  );

  // ASR and LSR keep the current overflow
  shift_unit shift_unit_inst (
    .op          (op),
    .operand     (operand),
    .overflow_in (cond_codes[CC_V]),
    .result      (shift_result),
    .flag_n      (shift_n),
    .flag_z      (shift_z),
    .flag_v      (shift_v),
    .flag_c      (shift_c)
  );

  accumulator_update accumulator_update_inst (
    .clk          (clk),
    .reset_b      (reset_b),
    .op_class     (op_class),
    .target_b     (target_b),
    .arith_result (arith_result),
    .arith_n      (arith_n),
    .arith_z      (arith_z),
    .arith_v      (arith_v),
    .arith_c      (arith_c),
    .shift_result (shift_result),
    .shift_n      (shift_n),
    .shift_z      (shift_z),
    .shift_v      (shift_v),
    .shift_c      (shift_c),
    .reg_a        (reg_a),
    .reg_b        (reg_b),
    .cond_codes   (cond_codes),
    .operand      (operand)
  );

endmodule

`default_nettype wire

// ==== design/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

  // --------------------------------------------------
  // Fetch sequencing
  // --------------------------------------------------

  // Reset, two vector bytes, then steady fetch
  typedef enum logic [1:0] {
    ST_RESET,
    ST_VEC_HI,
    ST_VEC_LO,
    ST_FETCH
  } fetch_state_t;

  // --------------------------------------------------
  // Execution
  // --------------------------------------------------

  // Decoded accumulator operation
  typedef enum logic [2:0] {
    OP_NONE,
    OP_CLR,
    OP_INC,
    OP_COM,
    OP_ASL,
    OP_ASR,
    OP_LSR
  } alu_op_t;

  // Which unit supplies the writeback
  typedef enum logic [1:0] {
    CLASS_NONE,
    CLASS_ARITH,
    CLASS_SHIFT
  } alu_class_t;

endpackage

`default_nettype wire

// ==== design/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

  // --------------------------------------------------
  // Data widths
  // --------------------------------------------------

  // One data byte on the bus
  typedef logic [7:0]  byte_t;

  // Address bus, big-endian vectors
  typedef logic [15:0] addr_t;

  // Condition code register
  typedef logic [7:0]  cc_t;

  // --------------------------------------------------
  // Condition code bit positions
  // --------------------------------------------------

  localparam int CC_E = 7;  // Entire state saved
  localparam int CC_F = 6;  // FIRQ mask
  localparam int CC_H = 5;  // Half carry
  localparam int CC_I = 4;  // IRQ mask
  localparam int CC_N = 3;  // Negative
  localparam int CC_Z = 2;  // Zero
  localparam int CC_V = 1;  // Overflow
  localparam int CC_C = 0;  // Carry

  // E, F and I set out of reset
  localparam cc_t CC_RESET = 8'hD0;

  // --------------------------------------------------
  // Reset vector, MSB first
  // --------------------------------------------------

  localparam addr_t RESET_VECTOR_HI = 16'hFFFE;
  localparam addr_t RESET_VECTOR_LO = 16'hFFFF;

  // --------------------------------------------------
  // Inherent accumulator opcodes
  // --------------------------------------------------

  // A forms, row 4x
  localparam byte_t OP_CLRA = 8'h4F;
  localparam byte_t OP_INCA = 8'h4C;
  localparam byte_t OP_COMA = 8'h43;
  localparam byte_t OP_ASLA = 8'h48;
  localparam byte_t OP_ASRA = 8'h47;
  localparam byte_t OP_LSRA = 8'h44;

  // B forms, row 5x
  localparam byte_t OP_CLRB = 8'h5F;
  localparam byte_t OP_INCB = 8'h5C;
  localparam byte_t OP_COMB = 8'h53;
  localparam byte_t OP_ASLB = 8'h58;
  localparam byte_t OP_ASRB = 8'h57;
  localparam byte_t OP_LSRB = 8'h54;

  // Architectural NOP, held in the IR until the first fetch
  localparam byte_t INSTR_NOP = 8'h12;

endpackage

`default_nettype wire

// ==== design/fetch_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_sequencer (
  input  wire                clk,
  input  wire                reset_b,
  input  wire cpu_isa_pkg::byte_t data_in,
  output cpu_isa_pkg::addr_t memory_addr,
  output logic               memory_rw_n,
  output cpu_isa_pkg::byte_t instr
);

  import cpu_isa_pkg::*;
  import core_ctrl_pkg::*;

  // --------------------------------------------------
  // Sequencer state
  // --------------------------------------------------

  fetch_state_t state;
  fetch_state_t state_next;

  // PC tracks the byte currently on the bus once fetching
  addr_t pc;
  addr_t pc_next;
  addr_t addr_next;

  // Read-only core, bus never writes
  assign memory_rw_n = 1'b1;

  // --------------------------------------------------
  // Next state, PC and address
  // --------------------------------------------------

  always_comb begin
    state_next = state;
    pc_next    = pc;
    addr_next  = memory_addr;
    case (state)
      ST_RESET: begin
        // Hold FFFE one more cycle for the MSB read
        state_next = ST_VEC_HI;
        addr_next  = RESET_VECTOR_HI;
      end
      ST_VEC_HI: begin
        // Vector MSB on data_in now
        state_next = ST_VEC_LO;
        pc_next    = {data_in, pc[7:0]};
        addr_next  = RESET_VECTOR_LO;
      end
      ST_VEC_LO: begin
        // Vector LSB completes the PC
        state_next = ST_FETCH;
        pc_next    = {pc[15:8], data_in};
        // Full vector goes out, not just the MSB half
        addr_next  = {pc[15:8], data_in};
      end
      ST_FETCH: begin
        // One opcode byte per clock
        pc_next   = pc + 16'd1;
        addr_next = pc + 16'd1;
      end
      default: begin
        state_next = ST_RESET;
        addr_next  = RESET_VECTOR_HI;
      end
    endcase
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state       <= ST_RESET;
      pc          <= '0;
      memory_addr <= RESET_VECTOR_HI;
    end else begin
      state       <= state_next;
      pc          <= pc_next;
      memory_addr <= addr_next;
    end
  end

  // Instruction register
  // Byte at the current address, executed next cycle
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      instr <= INSTR_NOP;
    end else if (state == ST_FETCH) begin
      instr <= data_in;
    end
  end

endmodule

`default_nettype wire

// ==== design/opcode_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module opcode_decode (
  input  wire cpu_isa_pkg::byte_t    instr,
  output core_ctrl_pkg::alu_op_t    op,
  output core_ctrl_pkg::alu_class_t op_class,
  output logic                      target_b
);

  import cpu_isa_pkg::*;
  import core_ctrl_pkg::*;

  // --------------------------------------------------
  // Operation lookup
  // --------------------------------------------------

  // Twelve inherent forms, all else is a NOP
  always_comb begin
    case (instr)
      OP_CLRA, OP_CLRB: begin
        op       = OP_CLR;
        op_class = CLASS_ARITH;
      end
      OP_INCA, OP_INCB: begin
        op       = OP_INC;
        op_class = CLASS_ARITH;
      end
      OP_COMA, OP_COMB: begin
        op       = OP_COM;
        op_class = CLASS_ARITH;
      end
      OP_ASLA, OP_ASLB: begin
        op       = OP_ASL;
        op_class = CLASS_SHIFT;
      end
      OP_ASRA, OP_ASRB: begin
        op       = OP_ASR;
        op_class = CLASS_SHIFT;
      end
      OP_LSRA, OP_LSRB: begin
        op       = OP_LSR;
        op_class = CLASS_SHIFT;
      end
      default: begin
        op       = OP_NONE;
        op_class = CLASS_NONE;
      end
    endcase
  end

  // --------------------------------------------------
  // Target accumulator
  // --------------------------------------------------

  // Row 5x is B, row 4x is A
  // Ignored for NOPs since nothing is written
  assign target_b = (instr[7:4] == 4'h5);

endmodule

`default_nettype wire

// ==== design/shift_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module shift_unit (
  input  wire core_ctrl_pkg::alu_op_t op,
  input  wire cpu_isa_pkg::byte_t     operand,
  input  wire                         overflow_in,
  output cpu_isa_pkg::byte_t          result,
  output logic                        flag_n,
  output logic                        flag_z,
  output logic                        flag_v,
  output logic                        flag_c
);

  import core_ctrl_pkg::*;

  // --------------------------------------------------
  // Shifter
  // --------------------------------------------------

  always_comb begin
    case (op)
      OP_ASL: begin
        // Zero into bit 0, old bit 7 out to carry
        result = {operand[6:0], 1'b0};
        flag_c = operand[7];
        // Sign changed by the shift
        flag_v = operand[7] ^ operand[6];
      end
      OP_ASR: begin
        // Sign bit replicated
        result = {operand[7], operand[7:1]};
        flag_c = operand[0];
        flag_v = overflow_in;
      end
      OP_LSR: begin
        // Zero into bit 7
        result = {1'b0, operand[7:1]};
        flag_c = operand[0];
        flag_v = overflow_in;
      end
      default: begin
        result = operand;
        flag_c = 1'b0;
        flag_v = overflow_in;
      end
    endcase
  end

  // --------------------------------------------------
  // N and Z
  // --------------------------------------------------

  // LSR always clears N, result bit 7 is zero
  assign flag_n = result[7];
  assign flag_z = (result == 8'h00);

endmodule

`default_nettype wire

// ==== testbench/core6809_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module core6809_tb;

  import cpu_isa_pkg::*;

  // --------------------------------------------------
  // Run length and test indices
  // --------------------------------------------------

  localparam int PROG_LEN     = 200;
  localparam int RAND_SEED    = 66327;
  localparam int NUM_DIRECTED = 17;
  localparam int WATCHDOG_NS  = (PROG_LEN + 20) * 8;

  localparam int T_RESET   = 0;
  localparam int T_VECTOR  = 1;
  localparam int T_SEQ     = 2;
  localparam int T_ARITH   = 3;
  localparam int T_SHIFT   = 4;
  localparam int T_UNSUP   = 5;
  localparam int NUM_TESTS = 6;

  logic  clk;
  logic  reset_b;
  byte_t data_in;
  addr_t memory_addr;
  logic  memory_rw_n;
  byte_t reg_a;
  byte_t reg_b;
  cc_t   cond_codes;

  // 64 KiB memory and program entry point
  byte_t mem [0:65535];
  addr_t vector;

  // Reference model copies
  addr_t exp_addr;
  byte_t exp_a;
  byte_t exp_b;
  cc_t   exp_cc;
  int    addr_test;
  int    exec_test;
  int    edge_count;
  int    errors [NUM_TESTS];
  int    checks [NUM_TESTS];
  int    failed_tests;
  logic  hit_inc_7f;
  logic  hit_inc_ff;
  logic  hit_shift_msb;

  tb_clock_gen clock_gen_inst (
    .clk     (clk),
    .reset_b (reset_b)
  );

  core6809 core6809_inst (
    .clk         (clk),
    .reset_b     (reset_b),
    .data_in     (data_in),
    .memory_addr (memory_addr),
    .memory_rw_n (memory_rw_n),
    .reg_a       (reg_a),
    .reg_b       (reg_b),
    .cond_codes  (cond_codes)
  );

  // --------------------------------------------------
  // Opcode tables
  // --------------------------------------------------

  function automatic string test_name(input int idx);
    case (idx)
      T_RESET:  return "reset_state";
      T_VECTOR: return "vector_fetch";
      T_SEQ:    return "sequential_fetch";
      T_ARITH:  return "arith_ops";
      T_SHIFT:  return "shift_ops";
      default:  return "unsupported_opcodes";
    endcase
  endfunction

  function automatic byte_t kept_opcode(input int idx);
    case (idx)
      0:       return OP_CLRA;
      1:       return OP_INCA;
      2:       return OP_COMA;
      3:       return OP_ASLA;
      4:       return OP_ASRA;
      5:       return OP_LSRA;
      6:       return OP_CLRB;
      7:       return OP_INCB;
      8:       return OP_COMB;
      9:       return OP_ASLB;
      10:      return OP_ASRB;
      default: return OP_LSRB;
    endcase
  endfunction

  function automatic logic is_kept_opcode(input byte_t opcode);
    logic found;
    found = 1'b0;
    for (int k = 0; k < 12; k++) begin
      if (kept_opcode(k) == opcode) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // Opening sequence that reaches the corner cases
  function automatic byte_t directed_opcode(input int idx);
    case (idx)
      0:       return OP_CLRA;
      1:       return OP_COMA;   // A = FF
      2:       return OP_INCA;   // FF wraps to 00
      3:       return OP_COMA;
      4:       return OP_LSRA;   // A = 7F
      5:       return OP_INCA;   // 7F to 80, overflow
      6:       return OP_ASLA;   // Bit 7 set going in
      7:       return OP_COMA;
      8:       return OP_ASRA;   // Sign kept
      9:       return OP_LSRA;
      10:      return INSTR_NOP;
      11:      return OP_CLRB;
      12:      return OP_COMB;
      13:      return OP_INCB;
      14:      return OP_COMB;
      15:      return OP_ASLB;
      default: return OP_ASRB;
    endcase
  endfunction

  // --------------------------------------------------
  // Program image
  // --------------------------------------------------

  task automatic build_program();
    byte_t filler;
    addr_t loc;
    // Background pattern from both address bytes
    for (int i = 0; i < 65536; i++) begin
      mem[i] = i[15:8] ^ i[7:0] ^ 8'hA5;
    end
    vector = addr_t'(32'h0100 + ($urandom % 32'h7000));
    // Big-endian vector
    mem[RESET_VECTOR_HI] = vector[15:8];
    mem[RESET_VECTOR_LO] = vector[7:0];
    for (int i = 0; i < PROG_LEN; i++) begin
      loc = addr_t'(vector + i);
      if (i < NUM_DIRECTED) begin
        mem[loc] = directed_opcode(i);
      end else if (($urandom % 4) != 0) begin
        mem[loc] = kept_opcode(int'($urandom % 12));
      end else begin
        filler = byte_t'($urandom);
        while (is_kept_opcode(filler)) begin
          filler = byte_t'($urandom);
        end
        mem[loc] = filler;
      end
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  task automatic execute_model(input byte_t opcode, output int test_idx);
    byte_t x;
    byte_t r;
    logic  use_b;
    logic  v;
    logic  c;
    test_idx = T_UNSUP;
    if (is_kept_opcode(opcode)) begin
      case (opcode)
        OP_CLRB, OP_INCB, OP_COMB, OP_ASLB, OP_ASRB, OP_LSRB: use_b = 1'b1;
        default: use_b = 1'b0;
      endcase
      x = use_b ? exp_b : exp_a;
      r = x;
      v = exp_cc[CC_V];
      c = exp_cc[CC_C];
      case (opcode)
        OP_CLRA, OP_CLRB: begin
          r = 8'h00;
          v = 1'b0;
          c = 1'b0;
          test_idx = T_ARITH;
        end
        OP_INCA, OP_INCB: begin
          // Carry left alone
          r = x + 8'd1;
          v = (x == 8'h7F);
          hit_inc_7f = hit_inc_7f | (x == 8'h7F);
          hit_inc_ff = hit_inc_ff | (x == 8'hFF);
          test_idx = T_ARITH;
        end
        OP_COMA, OP_COMB: begin
          r = ~x;
          v = 1'b0;
          c = 1'b1;
          test_idx = T_ARITH;
        end
        OP_ASLA, OP_ASLB: begin
          r = {x[6:0], 1'b0};
          c = x[7];
          v = x[7] ^ x[6];
          test_idx = T_SHIFT;
        end
        OP_ASRA, OP_ASRB: begin
          r = {x[7], x[7:1]};
          c = x[0];
          test_idx = T_SHIFT;
        end
        default: begin
          // LSR, zero shifted into bit 7
          r = {1'b0, x[7:1]};
          c = x[0];
          test_idx = T_SHIFT;
        end
      endcase
      if (test_idx == T_SHIFT) begin
        hit_shift_msb = hit_shift_msb | x[7];
      end
      // H, E, F and I never touched
      exp_cc[CC_N] = r[7];
      exp_cc[CC_Z] = (r == 8'h00);
      exp_cc[CC_V] = v;
      exp_cc[CC_C] = c;
      if (use_b) begin
        exp_b = r;
      end else begin
        exp_a = r;
      end
    end
  endtask

  // Expected bus and registers after edge number edge_count
  task automatic advance_model();
    case (edge_count)
      1: begin
        exp_addr  = RESET_VECTOR_HI;
        addr_test = T_VECTOR;
      end
      2: exp_addr = RESET_VECTOR_LO;
      3: exp_addr = vector;
      default: begin
        exp_addr  = exp_addr + 16'd1;
        addr_test = T_SEQ;
      end
    endcase
    // Byte fetched at V+k runs two edges after V+k went out
    if (edge_count >= 5) begin
      execute_model(mem[addr_t'(vector + edge_count - 5)], exec_test);
    end
  endtask

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------

  task automatic report_mismatch(input int idx, input string what,
                                 input logic [15:0] expected, input logic [15:0] actual);
    errors[idx]++;
    $display("Mismatch %s %s: expected %0h, actual %0h",
             test_name(idx), what, expected, actual);
  endtask

  task automatic print_test_result(input int idx);
    if (checks[idx] == 0) begin
      errors[idx]++;
      $display("%s: no check was ever reached", test_name(idx));
    end else if (errors[idx] == 0) begin
      $display("%s: ok, %0d checks", test_name(idx), checks[idx]);
    end else begin
      $display("%s: FAILED, %0d of %0d checks wrong", test_name(idx), errors[idx], checks[idx]);
    end
  endtask

  // --------------------------------------------------
  // Checks, sampled mid-cycle
  // --------------------------------------------------

  addr_check: assert property (@(negedge clk) memory_addr == exp_addr)
    else report_mismatch(addr_test, "memory_addr", exp_addr, memory_addr);

  rw_check: assert property (@(negedge clk) memory_rw_n == 1'b1)
    else report_mismatch(addr_test, "memory_rw_n", 16'h0001, {15'h0, memory_rw_n});

  a_check: assert property (@(negedge clk) reg_a == exp_a)
    else report_mismatch(exec_test, "reg_a", {8'h00, exp_a}, {8'h00, reg_a});

  b_check: assert property (@(negedge clk) reg_b == exp_b)
    else report_mismatch(exec_test, "reg_b", {8'h00, exp_b}, {8'h00, reg_b});

  cc_check: assert property (@(negedge clk) cond_codes == exp_cc)
    else report_mismatch(exec_test, "cond_codes", {8'h00, exp_cc}, {8'h00, cond_codes});

  // Bus checks go to the fetch tests, register checks to the last instruction
  always @(negedge clk) begin
    checks[addr_test] += 2;
    checks[exec_test] += 3;
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin
    void'($urandom(RAND_SEED));
    for (int i = 0; i < NUM_TESTS; i++) begin
      errors[i] = 0;
      checks[i] = 0;
    end
    exp_addr      = RESET_VECTOR_HI;
    exp_a         = 8'h00;
    exp_b         = 8'h00;
    exp_cc        = CC_RESET;
    addr_test     = T_RESET;
    exec_test     = T_RESET;
    edge_count    = 0;
    hit_inc_7f    = 1'b0;
    hit_inc_ff    = 1'b0;
    hit_shift_msb = 1'b0;
    failed_tests  = 0;
    build_program();
    // Address sits at FFFE all through reset
    data_in = mem[RESET_VECTOR_HI];
    @(posedge reset_b);
    repeat (PROG_LEN + 4) begin
      @(posedge clk);
      #1;
      edge_count++;
      advance_model();
      if (edge_count == 5) begin
        print_test_result(T_RESET);
        print_test_result(T_VECTOR);
      end
      data_in = mem[memory_addr];
    end
    @(negedge clk);
    #1;
    print_test_result(T_SEQ);
    if (!hit_inc_7f || !hit_inc_ff) begin
      errors[T_ARITH]++;
      $display("INC of 7F or of FF was never executed");
    end
    print_test_result(T_ARITH);
    if (!hit_shift_msb) begin
      errors[T_SHIFT]++;
      $display("No shift ran on an operand with bit 7 set");
    end
    print_test_result(T_SHIFT);
    print_test_result(T_UNSUP);
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (errors[i] != 0) begin
        failed_tests++;
      end
    end
    $display("results: %0d passed, %0d failed", NUM_TESTS - failed_tests, failed_tests);
    if (failed_tests == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #WATCHDOG_NS;
    $display("Watchdog expired after %0d ns, the run never completed", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset_b
);

  localparam int HALF_PERIOD_NS = 4;
  localparam int RESET_CYCLES   = 5;

  // Free running 8 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD_NS clk = ~clk;
    end
  end

  // Reset released just after an edge, like other inputs
  initial begin
    reset_b = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset_b = 1'b1;
  end

endmodule

`default_nettype wire
